// ==== list.f ====
verilog/oflow_cr_pkg.sv
verilog/oflow_score_board.sv
verilog/oflow_id_lut.sv
verilog/oflow_conflict_resolve_fsm.sv
verilog/oflow_cr_top.sv
verif/oflow_tb_clock.sv
verif/oflow_cr_tb.sv

// ==== run.sh ====
#!/bin/sh
# build the conflict resolve testbench with verilator, run it, judge the log
rm -f sim.log
verilator --binary --timing -Wno-fatal -f list.f --top-module oflow_cr_tb \
	-o oflow_cr_sim > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/oflow_cr_sim > sim.log 2>&1 || echo "simulator returned an error" >> sim.log
cat sim.log
grep -q "Some tests failed" sim.log && { echo "simulation FAILED"; exit 1; }
grep -q "All tests passed" sim.log || { echo "no pass line in sim.log"; exit 1; }
echo "simulation passed"
exit 0

// ==== verif/oflow_cr_tb.sv ====
// directed and random frame tests for the conflict resolve stage
`timescale 1ns/10ps
`default_nettype none

module oflow_cr_tb;
	import oflow_cr_pkg::*;

	// must match the dut defaults
	localparam int ROWS             = 4;
	localparam int PES              = 4;
	localparam int MAX_CONFLICTS_TH = 3;
	localparam int NUM_FRAMES       = 15;
	localparam int DONE_LIMIT       = 200;

	logic       clk;
	logic       reset_N;
	sb_load_t   load;
	logic       start;
	logic [ROW_LEN-1:0] rd_row;
	logic [PE_LEN-1:0]  rd_pe;
	sb_entry_t  rd_entry;
	cr_status_t status;

	// frame under test and expected result
	logic [ID_LEN-1:0]    frame_id    [ROWS][PES];
	logic [SCORE_LEN-1:0] frame_score [ROWS][PES];
	logic                 exp_fb      [ROWS][PES];
	logic                 exp_th;

	// model bookkeeping per id
	int                   occ        [1 << ID_LEN];
	logic [SCORE_LEN-1:0] best_score [1 << ID_LEN];
	int                   best_row   [1 << ID_LEN];
	int                   best_pe    [1 << ID_LEN];

	oflow_tb_clock #(.RESET_CYCLES(5)) u_clock (.clk(clk), .reset_N(reset_N));

	oflow_cr_top UUT (
		.clk(clk), .reset_N(reset_N), .load(load), .start(start),
		.rd_row(rd_row), .rd_pe(rd_pe), .rd_entry(rd_entry), .status(status)
	);

	// ------------------------------
	// check and reference model
	// ------------------------------
	task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
		if (got !== exp) begin
			$display("** Error at %0t ns: %s = 0x%0h, expected 0x%0h", $time, name, got, exp);
			$display("Some tests failed");
			$fatal(1, "stopped at first mismatch");
		end
	endtask

	// row-major walk, lower score wins, tie goes against the newer cell
	task automatic predict_frame();
		logic [ID_LEN-1:0] id;
		bit                stop;
		for (int i = 0; i < (1 << ID_LEN); i++) begin
			occ[i] = 0;
		end
		stop   = 0;
		exp_th = 1'b0;
		for (int r = 0; r < ROWS; r++) begin
			for (int p = 0; p < PES; p++) begin
				exp_fb[r][p] = 1'b0;
			end
		end
		for (int r = 0; r < ROWS; r++) begin
			for (int p = 0; p < PES; p++) begin
				id = frame_id[r][p];
				if (!stop && id == '0) begin
					stop = 1;
				end else if (!stop) begin
					if (occ[id] == 0 || frame_score[r][p] < best_score[id]) begin
						// earlier best, if any, becomes the loser
						if (occ[id] != 0) begin
							exp_fb[best_row[id]][best_pe[id]] = 1'b1;
						end
						best_score[id] = frame_score[r][p];
						best_row[id]   = r;
						best_pe[id]    = p;
					end else begin
						exp_fb[r][p] = 1'b1;
					end
					// occurrence MAX_CONFLICTS_TH+1 stops the scan
					if (occ[id] == MAX_CONFLICTS_TH) begin
						exp_th = 1'b1;
						stop   = 1;
					end
					occ[id]++;
				end
			end
		end
	endtask

	// ------------------------------
	// frame helpers
	// ------------------------------
	task automatic fill_distinct(input int base);
		for (int r = 0; r < ROWS; r++) begin
			for (int p = 0; p < PES; p++) begin
				frame_id[r][p]    = ID_LEN'(base + r * PES + p);
				frame_score[r][p] = SCORE_LEN'($urandom_range(0, 255));
			end
		end
	endtask

	task automatic set_cell(input int r, input int p, input int id, input int score);
		frame_id[r][p]    = ID_LEN'(id);
		frame_score[r][p] = SCORE_LEN'(score);
	endtask

	// load, start, wait for done, read back
	task automatic run_frame(input string tag);
		int n;
		$display("running %s", tag);
		predict_frame();
		for (int r = 0; r < ROWS; r++) begin
			for (int p = 0; p < PES; p++) begin
				@(posedge clk);
				load.valid <= 1'b1;
				load.row   <= ROW_LEN'(r);
				load.pe    <= PE_LEN'(p);
				load.id    <= frame_id[r][p];
				load.score <= frame_score[r][p];
			end
		end
		@(posedge clk);
		load  <= '0;
		start <= 1'b1;
		@(posedge clk);
		start <= 1'b0;
		n = 0;
		@(negedge clk);
		while (!status.done && n < DONE_LIMIT) begin
			n++;
			@(negedge clk);
		end
		if (!status.done) begin
			$display("%s: done did not arrive within %0d cycles", tag, DONE_LIMIT);
			$display("Some tests failed");
			$fatal(1, "scan never finished");
		end
		check_value("status.conflict_th", status.conflict_th, exp_th);
		@(negedge clk);
		// done lasts one cycle
		check_value("status.done", status.done, 1'b0);
		for (int r = 0; r < ROWS; r++) begin
			for (int p = 0; p < PES; p++) begin
				@(posedge clk);
				rd_row <= ROW_LEN'(r);
				rd_pe  <= PE_LEN'(p);
				@(negedge clk);
				check_value($sformatf("rd_entry.id[%0d][%0d]", r, p), rd_entry.id, frame_id[r][p]);
				check_value($sformatf("rd_entry.score[%0d][%0d]", r, p),
					rd_entry.score, frame_score[r][p]);
				check_value($sformatf("rd_entry.fallback[%0d][%0d]", r, p),
					rd_entry.fallback, exp_fb[r][p]);
			end
		end
	endtask

	// ------------------------------
	// directed tests
	// ------------------------------
	task automatic test_distinct();
		fill_distinct(1);
		run_frame("distinct ids");
	endtask

	task automatic test_pair();
		fill_distinct(12'h100);
		set_cell(0, 1, 12'h005, 20);
		set_cell(1, 2, 12'h005, 10);
		// equal scores, later cell loses
		set_cell(2, 0, 12'h007, 30);
		set_cell(3, 3, 12'h007, 30);
		// same lut word, other half
		set_cell(0, 3, 12'h009, 40);
		set_cell(2, 2, 12'h809, 50);
		run_frame("pairs and tie");
		check_value("u_id_lut.seen[009]", UUT.u_id_lut.seen[11'h009], 2'b11);
	endtask

	task automatic test_triple();
		fill_distinct(12'h200);
		set_cell(0, 0, 12'h020, 50);
		set_cell(1, 1, 12'h020, 15);
		set_cell(2, 3, 12'h020, 40);
		run_frame("three occurrences");
	endtask

	task automatic test_zero_id();
		fill_distinct(12'h300);
		set_cell(0, 2, 12'h030, 10);
		set_cell(1, 1, 0, 0);
		// duplicate past the end marker
		set_cell(2, 0, 12'h030, 90);
		run_frame("zero id ends frame");
	endtask

	task automatic test_threshold();
		fill_distinct(12'h400);
		set_cell(0, 0, 12'h040, 60);
		set_cell(0, 2, 12'h040, 50);
		set_cell(1, 0, 12'h040, 70);
		set_cell(1, 3, 12'h040, 40);
		set_cell(2, 1, 12'h040, 10);
		run_frame("conflict threshold");
	endtask

	// small id pool, both halves, rare end marker
	task automatic test_random();
		logic [ID_LEN-1:0] id;
		for (int f = 0; f < 10; f++) begin
			for (int r = 0; r < ROWS; r++) begin
				for (int p = 0; p < PES; p++) begin
					id = ID_LEN'($urandom_range(1, 5));
					if ($urandom_range(0, 1) == 1) begin
						id[ID_LEN-1] = 1'b1;
					end
					if ($urandom_range(0, 24) == 0) begin
						id = '0;
					end
					set_cell(r, p, id, $urandom_range(0, 15));
				end
			end
			run_frame($sformatf("random frame %0d", f));
		end
	endtask

	// ------------------------------
	// main sequence and watchdog
	// ------------------------------
	initial begin
		load   = '0;
		start  = 1'b0;
		rd_row = '0;
		rd_pe  = '0;
		void'($urandom(43));
		wait (reset_N === 1'b1);
		@(posedge clk);
		test_distinct();
		test_pair();
		test_triple();
		test_zero_id();
		test_threshold();
		test_random();
		$display("All tests passed");
		$finish;
	end

	initial begin
		repeat ((NUM_FRAMES + 1) * 200) @(posedge clk);
		$display("watchdog expired before the tests finished");
		$display("Some tests failed");
		$fatal(1, "run took too long");
	end

endmodule

`default_nettype wire

// ==== verif/oflow_tb_clock.sv ====
// testbench clock and reset source, 4 ns period with a 5 cycle reset
`timescale 1ns/10ps
`default_nettype none

module oflow_tb_clock #(
	parameter int RESET_CYCLES = 5
) (
	output logic clk,
	output logic reset_N
);
	// 2 ns half period
	initial begin
		clk = 1'b0;
		forever #2 clk = ~clk;
	end

	initial begin
		reset_N = 1'b0;
		repeat (RESET_CYCLES) @(posedge clk);
		reset_N <= 1'b1;
	end

endmodule

`default_nettype wire

// ==== verilog/oflow_conflict_resolve_fsm.sv ====
// conflict resolve scan fsm with per-slot histogram and loser marking
`timescale 1ns/10ps
`default_nettype none

module oflow_conflict_resolve_fsm #(
	parameter int ROWS             = 4,
	parameter int PES              = 4,
	parameter int MAX_BBOXES       = 32,
	parameter int MAX_CONFLICTS_TH = 3
) (
	input  logic                              clk,
	input  logic                              reset_N,
	input  logic                              start,
	input  oflow_cr_pkg::sb_entry_t           sel_entry,
	input  logic [oflow_cr_pkg::SLOT_LEN-1:0] lut_slot,
	input  logic                              lut_seen,
	output oflow_cr_pkg::cr_status_t          status,
	output logic [oflow_cr_pkg::ROW_LEN-1:0]  sel_row,
	output logic [oflow_cr_pkg::PE_LEN-1:0]   sel_pe,
	output oflow_cr_pkg::sb_mark_t            mark,
	output logic [oflow_cr_pkg::ID_LEN-1:0]   lut_id,
	output logic                              lut_we,
	output logic [oflow_cr_pkg::SLOT_LEN-1:0] lut_new_slot,
	output logic                              lut_clear
);
	import oflow_cr_pkg::*;

	// histogram index and occurrence counter widths
	localparam int HW      = (MAX_BBOXES > 1) ? $clog2(MAX_BBOXES) : 1;
	localparam int CNT_LEN = $clog2(MAX_CONFLICTS_TH + 2);

	typedef enum logic [1:0] {
		idle_st,
		row_st,
		lookup_st,
		hist_st
	} state_t;

	state_t state;
	state_t next_state;

	// scan position, row counter one bit wider to reach ROWS
	logic [ROW_LEN:0]    row_cnt;
	logic [PE_LEN-1:0]   pe_cnt;
	logic [SLOT_LEN-1:0] distinct_cnt;
	logic [SLOT_LEN-1:0] new_slot;

	// candidate under test
	logic [PE_LEN-1:0]    cur_pe;
	logic [SCORE_LEN-1:0] cur_score;
	logic [SLOT_LEN-1:0]  cur_slot;
	logic [HW-1:0]        hidx;

	// histogram per slot
	logic [CNT_LEN-1:0]   hist_cnt [MAX_BBOXES];
	logic [SCORE_LEN-1:0] hist_min [MAX_BBOXES];
	logic [ROW_LEN-1:0]   hist_row [MAX_BBOXES];
	logic [PE_LEN-1:0]    hist_pe  [MAX_BBOXES];

	logic [CNT_LEN-1:0] old_cnt;
	logic               hist_upd;

	assign sel_row      = row_cnt[ROW_LEN-1:0];
	assign sel_pe       = pe_cnt;
	assign lut_id       = sel_entry.id;
	// slots start at 1
	assign new_slot     = distinct_cnt + 1'b1;
	assign lut_new_slot = new_slot;
	assign hidx         = HW'(cur_slot - 1'b1);
	assign old_cnt      = hist_cnt[hidx];

	// ------------------------------
	// next state and pulses
	// ------------------------------
	always_comb begin
		next_state = state;
		status     = '0;
		mark       = '{1'b0, row_cnt[ROW_LEN-1:0], cur_pe};
		lut_we     = 1'b0;
		lut_clear  = 1'b0;
		hist_upd   = 1'b0;
		case (state)
			idle_st: begin
				if (start) begin
					lut_clear  = 1'b1;
					next_state = row_st;
				end
			end
			row_st: begin
				// all rows visited
				if (row_cnt == (ROW_LEN + 1)'(ROWS)) begin
					status.done = 1'b1;
					next_state  = idle_st;
				end else begin
					next_state = lookup_st;
				end
			end
			lookup_st: begin
				// id zero ends the frame
				if (sel_entry.id == '0) begin
					status.done = 1'b1;
					next_state  = idle_st;
				end else begin
					lut_we     = !lut_seen;
					next_state = hist_st;
				end
			end
			hist_st: begin
				if (old_cnt != '0) begin
					mark.valid = 1'b1;
					// new one wins, previous best loses
					if (cur_score < hist_min[hidx]) begin
						mark.row = hist_row[hidx];
						mark.pe  = hist_pe[hidx];
						hist_upd = 1'b1;
					end
				end else begin
					hist_upd = 1'b1;
				end
				if (old_cnt >= CNT_LEN'(MAX_CONFLICTS_TH)) begin
					status.done        = 1'b1;
					status.conflict_th = 1'b1;
					next_state         = idle_st;
				end else if (cur_pe == PE_LEN'(PES - 1)) begin
					next_state = row_st;
				end else begin
					next_state = lookup_st;
				end
			end
			default: next_state = idle_st;
		endcase
	end

	// ------------------------------
	// control registers
	// ------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			state        <= idle_st;
			row_cnt      <= '0;
			pe_cnt       <= '0;
			distinct_cnt <= '0;
		end else begin
			state <= next_state;
			if (state == idle_st && start) begin
				row_cnt      <= '0;
				distinct_cnt <= '0;
			end
			// each row scan begins at pe 0
			if (state == row_st) begin
				pe_cnt <= '0;
			end
			if (state == lookup_st && next_state == hist_st) begin
				pe_cnt <= pe_cnt + 1'b1;
				if (!lut_seen) begin
					distinct_cnt <= new_slot;
				end
			end
			if (state == hist_st && next_state == row_st) begin
				row_cnt <= row_cnt + 1'b1;
			end
		end
	end

	// registered candidate, new ids take the next free slot
	always_ff @(posedge clk) begin
		if (state == lookup_st) begin
			cur_pe    <= pe_cnt;
			cur_score <= sel_entry.score;
			cur_slot  <= lut_seen ? lut_slot : new_slot;
		end
	end

	// occurrence counts, cleared per frame
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			for (int i = 0; i < MAX_BBOXES; i++) begin
				hist_cnt[i] <= '0;
			end
		end else if (state == idle_st && start) begin
			for (int i = 0; i < MAX_BBOXES; i++) begin
				hist_cnt[i] <= '0;
			end
		end else if (state == hist_st) begin
			hist_cnt[hidx] <= old_cnt + 1'b1;
		end
	end

	// best score so far and where it sits
	always_ff @(posedge clk) begin
		if (hist_upd) begin
			hist_min[hidx] <= cur_score;
			hist_row[hidx] <= row_cnt[ROW_LEN-1:0];
			hist_pe[hidx]  <= cur_pe;
		end
	end

	a_slot_in_range : assert property (@(posedge clk) disable iff (!reset_N)
		lut_we |-> (lut_new_slot <= SLOT_LEN'(MAX_BBOXES)));

endmodule

`default_nettype wire

// ==== verilog/oflow_cr_pkg.sv ====
// conflict resolve shared widths and packed structs for score board, lut and fsm
`default_nettype none

package oflow_cr_pkg;

	// ------------------------------
	// widths
	// ------------------------------
	// object id, zero marks end of frame
	localparam int ID_LEN       = 12;
	// match score, lower is better
	localparam int SCORE_LEN    = 8;
	// score board indices
	localparam int ROW_LEN      = 3;
	localparam int PE_LEN       = 2;
	// lut word address from low id bits
	localparam int LUT_ADDR_LEN = 11;
	// histogram slot, zero means none
	localparam int SLOT_LEN     = 8;

	// ------------------------------
	// structs
	// ------------------------------
	// one candidate cell, 21 bits
	typedef struct packed {
		logic [ID_LEN-1:0]    id;
		logic [SCORE_LEN-1:0] score;
		logic                 fallback;
	} sb_entry_t;

	// external frame load, fallback cleared on write
	typedef struct packed {
		logic                 valid;
		logic [ROW_LEN-1:0]   row;
		logic [PE_LEN-1:0]    pe;
		logic [ID_LEN-1:0]    id;
		logic [SCORE_LEN-1:0] score;
	} sb_load_t;

	// loser marking from the fsm
	typedef struct packed {
		logic               valid;
		logic [ROW_LEN-1:0] row;
		logic [PE_LEN-1:0]  pe;
	} sb_mark_t;

	typedef struct packed {
		logic done;
		logic conflict_th;
	} cr_status_t;

endpackage

`default_nettype wire

// ==== verilog/oflow_cr_top.sv ====
// conflict resolve top, ties score board, id lut and scan fsm together
`timescale 1ns/10ps
`default_nettype none

module oflow_cr_top #(
	parameter int ROWS             = 4,
	parameter int PES              = 4,
	parameter int MAX_BBOXES       = 32,
	parameter int MAX_CONFLICTS_TH = 3
) (
	input  logic                             clk,
	input  logic                             reset_N,
	input  oflow_cr_pkg::sb_load_t           load,
	input  logic                             start,
	input  logic [oflow_cr_pkg::ROW_LEN-1:0] rd_row,
	input  logic [oflow_cr_pkg::PE_LEN-1:0]  rd_pe,
	output oflow_cr_pkg::sb_entry_t          rd_entry,
	output oflow_cr_pkg::cr_status_t         status
);
	import oflow_cr_pkg::*;

	// ------------------------------
	// fsm to score board
	// ------------------------------
	logic [ROW_LEN-1:0] sel_row;
	logic [PE_LEN-1:0]  sel_pe;
	sb_entry_t          sel_entry;
	sb_mark_t           mark;

	// fsm to lut
	logic [ID_LEN-1:0]   lut_id;
	logic                lut_we;
	logic [SLOT_LEN-1:0] lut_new_slot;
	logic                lut_clear;
	logic [SLOT_LEN-1:0] lut_slot;
	logic                lut_seen;

	oflow_score_board #(.ROWS(ROWS), .PES(PES)) u_score_board (
		.clk(clk), .reset_N(reset_N), .load(load),
		.sel_row(sel_row), .sel_pe(sel_pe), .rd_row(rd_row), .rd_pe(rd_pe),
		.mark(mark), .sel_entry(sel_entry), .rd_entry(rd_entry)
	);

	oflow_id_lut u_id_lut (
		.clk(clk), .reset_N(reset_N), .lut_id(lut_id), .lut_we(lut_we),
		.lut_new_slot(lut_new_slot), .lut_clear(lut_clear),
		.lut_slot(lut_slot), .lut_seen(lut_seen)
	);

	oflow_conflict_resolve_fsm #(
		.ROWS(ROWS), .PES(PES), .MAX_BBOXES(MAX_BBOXES), .MAX_CONFLICTS_TH(MAX_CONFLICTS_TH)
	) u_cr_fsm (
		.clk(clk), .reset_N(reset_N), .start(start), .sel_entry(sel_entry),
		.lut_slot(lut_slot), .lut_seen(lut_seen), .status(status),
		.sel_row(sel_row), .sel_pe(sel_pe), .mark(mark), .lut_id(lut_id),
		.lut_we(lut_we), .lut_new_slot(lut_new_slot), .lut_clear(lut_clear)
	);

endmodule

`default_nettype wire

// ==== verilog/oflow_id_lut.sv ====
// id to histogram slot lookup, two ids per word with per-frame seen flags
`timescale 1ns/10ps
`default_nettype none

module oflow_id_lut (
	input  logic                              clk,
	input  logic                              reset_N,
	input  logic [oflow_cr_pkg::ID_LEN-1:0]   lut_id,
	input  logic                              lut_we,
	input  logic [oflow_cr_pkg::SLOT_LEN-1:0] lut_new_slot,
	input  logic                              lut_clear,
	output logic [oflow_cr_pkg::SLOT_LEN-1:0] lut_slot,
	output logic                              lut_seen
);
	import oflow_cr_pkg::*;

	localparam int LUT_DEPTH = 1 << LUT_ADDR_LEN;

	// two slot halves per word
	logic [1:0][SLOT_LEN-1:0] mem  [LUT_DEPTH];
	// one seen bit per half
	logic [1:0]               seen [LUT_DEPTH];

	logic [LUT_ADDR_LEN-1:0] addr;
	logic                    half;

	// ------------------------------
	// address decode
	// ------------------------------
	assign addr = lut_id[LUT_ADDR_LEN-1:0];
	// top id bit set picks the low half
	assign half = ~lut_id[ID_LEN-1];

	assign lut_slot = mem[addr][half];
	assign lut_seen = seen[addr][half];

	// slot storage, only the selected half changes
	always_ff @(posedge clk) begin
		if (lut_we) begin
			mem[addr][half] <= lut_new_slot;
		end
	end

	// seen flags, wiped at every frame start
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			for (int i = 0; i < LUT_DEPTH; i++) begin
				seen[i] <= 2'b00;
			end
		end else if (lut_clear) begin
			for (int i = 0; i < LUT_DEPTH; i++) begin
				seen[i] <= 2'b00;
			end
		end else if (lut_we) begin
			seen[addr][half] <= 1'b1;
		end
	end

	a_we_not_clear : assert property (@(posedge clk) disable iff (!reset_N)
		!(lut_we && lut_clear));

endmodule

`default_nettype wire

// ==== verilog/oflow_score_board.sv ====
// candidate score board with external load, scan read and fallback marking
`timescale 1ns/10ps
`default_nettype none

module oflow_score_board #(
	parameter int ROWS = 4,
	parameter int PES  = 4
) (
	input  logic                              clk,
	input  logic                              reset_N,
	input  oflow_cr_pkg::sb_load_t            load,
	input  logic [oflow_cr_pkg::ROW_LEN-1:0]  sel_row,
	input  logic [oflow_cr_pkg::PE_LEN-1:0]   sel_pe,
	input  logic [oflow_cr_pkg::ROW_LEN-1:0]  rd_row,
	input  logic [oflow_cr_pkg::PE_LEN-1:0]   rd_pe,
	input  oflow_cr_pkg::sb_mark_t            mark,
	output oflow_cr_pkg::sb_entry_t           sel_entry,
	output oflow_cr_pkg::sb_entry_t           rd_entry
);
	import oflow_cr_pkg::*;

	// index widths sized to the real array
	localparam int RW = (ROWS > 1) ? $clog2(ROWS) : 1;
	localparam int PW = (PES > 1) ? $clog2(PES) : 1;

	sb_entry_t cells [ROWS][PES];

	// ------------------------------
	// read ports, no latency
	// ------------------------------
	// fsm scan port
	assign sel_entry = cells[sel_row[RW-1:0]][sel_pe[PW-1:0]];
	// external read-back
	assign rd_entry  = cells[rd_row[RW-1:0]][rd_pe[PW-1:0]];

	// ------------------------------
	// write side
	// ------------------------------
	always_ff @(posedge clk or negedge reset_N) begin
		if (!reset_N) begin
			for (int r = 0; r < ROWS; r++) begin
				for (int p = 0; p < PES; p++) begin
					cells[r][p] <= '0;
				end
			end
		end else begin
			// new candidate, fallback starts clear
			if (load.valid) begin
				cells[load.row[RW-1:0]][load.pe[PW-1:0]] <= '{load.id, load.score, 1'b0};
			end
			// loser from conflict resolve
			if (mark.valid) begin
				cells[mark.row[RW-1:0]][mark.pe[PW-1:0]].fallback <= 1'b1;
			end
		end
	end

	// load while the fsm marks the same cell means a load during a scan
	a_no_load_mark_clash : assert property (@(posedge clk) disable iff (!reset_N)
		(load.valid && mark.valid) |-> !(load.row == mark.row && load.pe == mark.pe));

	a_load_in_range : assert property (@(posedge clk) disable iff (!reset_N)
		load.valid |-> (load.row < ROWS && load.pe < PES));

	a_mark_in_range : assert property (@(posedge clk) disable iff (!reset_N)
		mark.valid |-> (mark.row < ROWS && mark.pe < PES));

endmodule

`default_nettype wire
